//--- cell_if.sv
interface cell_if
    import link_pkg::*;
();

    logic  push;
    col_t  x;
    row_t  y;
    char_t ch;
    // One pulse per entry leaving the cell queue
    logic  credit;

    modport tracker (output push, output x, output y, output ch, input credit);
    modport queue (input push, input x, input y, input ch, output credit);

endinterface

//--- cell_queue.sv
module cell_queue
    import link_pkg::*;
#(
    parameter int CELL_DEPTH = 4
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cell_busy,
    cell_if.queue cells,
    output logic  cell_valid,
    output col_t  cell_x,
    output row_t  cell_y,
    output char_t cell_char
);

    localparam int CELL_W = $bits(col_t) + $bits(row_t) + $bits(char_t);

    logic              empty;
    logic              accept;
    logic [CELL_W-1:0] head;

    // Credits bound the occupancy, so full is never reached by a push
    sync_fifo #(
        .WIDTH (CELL_W),
        .DEPTH (CELL_DEPTH)
    ) i_cell_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (cells.push),
        .wr_data ({cells.x, cells.y, cells.ch}),
        .rd_en   (accept),
        .rd_data (head),
        .full    (),
        .empty   (empty)
    );

    assign cell_valid                    = !empty;
    assign accept                        = cell_valid && !cell_busy;
    assign {cell_x, cell_y, cell_char}   = head;

    // One credit back per transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cells.credit <= 1'b0;
        end else begin
            cells.credit <= accept;
        end
    end

endmodule

//--- cursor_tracker.sv
module cursor_tracker
    import link_pkg::*;
#(
    parameter int CELL_DEPTH = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    cell_if.tracker    cells
);

    localparam int CRW = $clog2(CELL_DEPTH + 1);

    col_t           col;
    row_t           row;
    logic [CRW-1:0] credits;
    logic           pend;
    logic [7:0]     pend_byte;
    logic           is_cr;
    logic           is_lf;

    function automatic row_t wrap_row(row_t r);
        return (r == row_t'(GRID_ROWS - 1)) ? '0 : r + 1'b1;
    endfunction

    assign is_cr = (pend_byte == {1'b0, CHAR_CR});
    assign is_lf = (pend_byte == {1'b0, CHAR_LF});

    // Printable byte goes out as soon as a credit is held
    assign cells.push = pend && !is_cr && !is_lf && (credits != '0);
    assign cells.x    = col;
    assign cells.y    = row;
    assign cells.ch   = pend_byte[6:0];

    // ====================
    // Pending byte and credits
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend    <= 1'b0;
            credits <= CRW'(CELL_DEPTH);
        end else begin
            if (pend) begin
                if (is_cr || is_lf || cells.push) begin
                    pend <= 1'b0;
                end
            end else if (byte_valid) begin
                pend <= 1'b1;
            end
            if (cells.push && !cells.credit) begin
                credits <= credits - 1'b1;
            end else if (cells.credit && !cells.push) begin
                credits <= credits + 1'b1;
            end
        end
    end

    // New bytes are ignored while one waits
    always_ff @(posedge clk) begin
        if (byte_valid && !pend) begin
            pend_byte <= byte_data;
        end
    end

    // ====================
    // Cursor
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col <= '0;
            row <= '0;
        end else if (pend && is_cr) begin
            col <= '0;
            if (row != row_t'(GRID_ROWS - 1)) begin
                row <= row + 1'b1;
            end
        end else if (pend && is_lf) begin
            row <= wrap_row(row);
        end else if (cells.push) begin
            if (col == col_t'(GRID_COLS - 1)) begin
                col <= '0;
                row <= wrap_row(row);
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

//--- link_input.txt
# name kind byte(hex) count(dec) x(dec) y(dec) expected(hex)
# Kinds K key, B button, S key and button together, H host, P peer, W cell_busy cycles in count
key_plain   K 41 1    0 0  41
key_top_bit K c1 1    0 0  41
button      B da 1    0 0  5a
host_byte   H 93 1    0 0  13
key_vs_btn  S 37 1    0 0  37
row0_fill   P 41 80   0 0  41
col_wrap    P 42 1    0 1  42
cr_clamp    P 0d 30   0 0  00
bottom_row  P 43 1    0 29 43
lf_wrap     P 0a 1    0 0  00
top_row     P 44 1    1 0  44
busy_hold   W 00 1000 0 0  00
busy_c0     P c5 1    2 0  45
busy_c1     P 46 1    3 0  46
busy_c2     P 47 1    4 0  47
busy_c3     P 48 1    5 0  48
busy_c4     P 49 1    6 0  49

//--- link_pkg.sv
package link_pkg;

    // ====================
    // Text grid
    // ====================
    localparam int GRID_COLS = 80;
    localparam int GRID_ROWS = 30;

    typedef logic [6:0] col_t;
    typedef logic [4:0] row_t;
    typedef logic [6:0] char_t;

    // Control codes that move the cursor
    localparam char_t CHAR_CR = 7'd13;
    localparam char_t CHAR_LF = 7'd10;

    // ====================
    // FSM states
    // ====================
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    typedef enum logic [2:0] {TX_IDLE, TX_LOAD, TX_START, TX_DATA, TX_STOP} tx_state_e;

    // Outbound sources, listed in priority order
    typedef enum logic [1:0] {SRC_KEY, SRC_BTN, SRC_HOST} source_e;

endpackage

//--- run_sim.sh
#!/bin/sh
verilator --binary --top-module tb_terminal_link -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && ! grep -q "Finished with errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

//--- serial_rx.sv
module serial_rx
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       line,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic          line_meta;
    logic          line_sync;
    rx_state_e     state;
    logic [CW-1:0] count;
    logic [2:0]    bit_idx;

    // Two-flop synchroniser for a line that idles high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
        end else begin
            line_meta <= line;
            line_sync <= line_meta;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RX_IDLE;
            count      <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Half a bit to reach the middle of the start bit
                    if (!line_sync) begin
                        count <= CW'(CLKS_PER_BIT / 2 - 1);
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else if (line_sync) begin
                        // Glitch, not a real start bit
                        state <= RX_IDLE;
                    end else begin
                        count   <= CW'(CLKS_PER_BIT - 1);
                        bit_idx <= '0;
                        state   <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else begin
                        count   <= CW'(CLKS_PER_BIT - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else begin
                        byte_valid <= line_sync;  // bad stop bit drops the byte
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && count == '0) begin
            byte_data <= {line_sync, byte_data[7:1]};
        end
    end

endmodule

//--- serial_tx.sv
module serial_tx
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  empty,
    input  char_t head_char,
    output logic  pop,
    output logic  line
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    tx_state_e     state;
    logic [CW-1:0] count;
    logic [2:0]    bit_idx;
    logic [7:0]    shift_reg;

    // Pop one cycle before the stop bit ends so characters run back to back
    assign pop = !empty && (state == TX_IDLE || (state == TX_STOP && count == CW'(1)));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= TX_IDLE;
            count   <= '0;
            bit_idx <= '0;
            line    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pop) begin
                        state <= TX_LOAD;
                    end
                end
                TX_LOAD: begin
                    line  <= 1'b0;
                    count <= CW'(CLKS_PER_BIT - 1);
                    state <= TX_START;
                end
                TX_START: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else begin
                        line    <= shift_reg[0];
                        count   <= CW'(CLKS_PER_BIT - 1);
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else begin
                        count <= CW'(CLKS_PER_BIT - 1);
                        if (bit_idx == 3'd7) begin
                            line  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            line    <= shift_reg[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (pop) begin
                        state <= TX_LOAD;
                    end else if (count == '0) begin
                        state <= TX_IDLE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Character payload with the top bit always sent as zero
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= {1'b0, head_char};
        end else if (state == TX_DATA && count == '0) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule

//--- sim.f
link_pkg.sv
cell_if.sv
serial_rx.sv
serial_tx.sv
sync_fifo.sv
source_arbiter.sv
cursor_tracker.sv
cell_queue.sv
terminal_link_top.sv
tb_checker.sv
tb_terminal_link.sv

//--- source_arbiter.sv
module source_arbiter
    import link_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       key_valid,
    input  logic [7:0] key_code,
    input  logic       send_btn,
    input  logic [7:0] switches,
    input  logic       host_valid,
    input  logic [7:0] host_data,
    input  logic       queue_full,
    output logic       push,
    output char_t      push_char
);

    logic       key_prev;
    logic       btn_prev;
    logic       key_rise;
    logic       btn_rise;
    logic       grant_valid;
    source_e    grant;
    logic [7:0] grant_byte;

    assign key_rise = key_valid && !key_prev;
    assign btn_rise = send_btn && !btn_prev;

    // ====================
    // Fixed priority
    // ====================
    always_comb begin
        grant_valid = 1'b1;
        grant       = SRC_KEY;
        if (key_rise) begin
            grant = SRC_KEY;
        end else if (btn_rise) begin
            grant = SRC_BTN;
        end else if (host_valid) begin
            grant = SRC_HOST;
        end else begin
            grant_valid = 1'b0;
        end
    end

    always_comb begin
        case (grant)
            SRC_KEY: grant_byte = key_code;
            SRC_BTN: grant_byte = switches;
            default: grant_byte = host_data;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_prev <= 1'b0;
            btn_prev <= 1'b0;
            push     <= 1'b0;
        end else begin
            key_prev <= key_valid;
            btn_prev <= send_btn;
            // Event is lost when the queue has no room
            push     <= grant_valid && !queue_full;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            push_char <= grant_byte[6:0];
        end
    end

endmodule

//--- sync_fifo.sv
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             full,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int NW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [NW-1:0]    used;
    logic             do_wr;
    logic             do_rd;

    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && !empty;
    assign full    = (used == NW'(DEPTH));
    assign empty   = (used == '0);
    // Head entry, visible without a read cycle
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                used <= used + 1'b1;
            end else if (do_rd && !do_wr) begin
                used <= used - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- tb_checker.sv
module tb_checker
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  peer_tx,
    input  logic  cell_valid,
    input  logic  cell_busy,
    input  col_t  cell_x,
    input  row_t  cell_y,
    input  char_t cell_char,
    input  logic  end_of_test,
    output int    pending,
    output int    error_count,
    output int    checked,
    output logic  report_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    string      byte_names[$];
    logic [7:0] byte_exp[$];
    string      cell_names[$];
    col_t       cell_x_exp[$];
    row_t       cell_y_exp[$];
    char_t      cell_ch_exp[$];

    // ====================
    // Expected results
    // ====================
    task automatic load_expected();
        int         fd;
        int         i;
        int         count;
        int         cx;
        int         cy;
        string      line;
        string      name;
        string      kind;
        logic [7:0] data;
        logic [7:0] exp_byte;
        fd = $fopen("link_input.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open link_input.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%s %s %h %d %d %d %h", name, kind, data, count, cx, cy,
                            exp_byte) == 7) begin
                    if (kind == "K" || kind == "B" || kind == "S" || kind == "H") begin
                        for (i = 0; i < count; i++) begin
                            byte_names.push_back(name);
                            byte_exp.push_back(exp_byte);
                        end
                    end else if (kind == "P" && data != 8'h0d && data != 8'h0a) begin
                        // Repeated characters land at consecutive cursor positions
                        for (i = 0; i < count; i++) begin
                            cell_names.push_back(name);
                            cell_x_exp.push_back(col_t'(cx));
                            cell_y_exp.push_back(row_t'(cy));
                            cell_ch_exp.push_back(exp_byte[6:0]);
                            cx++;
                            if (cx == GRID_COLS) begin
                                cx = 0;
                                cy = (cy + 1) % GRID_ROWS;
                            end
                        end
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // ====================
    // Peer line
    // ====================
    task automatic receive_peer_byte();
        logic [7:0] got;
        string      name;
        logic [7:0] exp_byte;
        @(negedge peer_tx);
        // Middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (peer_tx !== 1'b0) begin
            $display("Start bit on peer_tx did not stay low at %0t", $time);
            error_count++;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            got[i] = peer_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (peer_tx !== 1'b1) begin
            $display("Stop bit on peer_tx was not high at %0t", $time);
            error_count++;
        end
        if (byte_exp.size() == 0) begin
            $display("Byte 0x%02h appeared on peer_tx with no event left to match it", got);
            error_count++;
        end else begin
            name     = byte_names.pop_front();
            exp_byte = byte_exp.pop_front();
            pending--;
            checked++;
            if (got !== exp_byte) begin
                $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp_byte, got);
                error_count++;
            end
        end
    endtask

    // ====================
    // Cell port
    // ====================
    task automatic capture_cell();
        string name;
        col_t  ex;
        row_t  ey;
        char_t ech;
        @(posedge clk);
        if (cell_valid === 1'b1 && cell_busy === 1'b0) begin
            if (cell_ch_exp.size() == 0) begin
                $display("Cell write at %0d,%0d with no peer character left to match it",
                         cell_x, cell_y);
                error_count++;
            end else begin
                name = cell_names.pop_front();
                ex   = cell_x_exp.pop_front();
                ey   = cell_y_exp.pop_front();
                ech  = cell_ch_exp.pop_front();
                pending--;
                checked++;
                if (cell_x !== ex || cell_y !== ey || cell_char !== ech) begin
                    $display("MISMATCH %s: expected (%0d,%0d,0x%02h), actual (%0d,%0d,0x%02h)",
                             name, ex, ey, ech, cell_x, cell_y, cell_char);
                    error_count++;
                end
            end
        end
    endtask

    task automatic report_leftovers();
        if (byte_exp.size() != 0) begin
            $display("%0d bytes never arrived on peer_tx, the first from test %s",
                     byte_exp.size(), byte_names[0]);
            error_count += byte_exp.size();
        end
        if (cell_ch_exp.size() != 0) begin
            $display("%0d cell writes never arrived, the first from test %s",
                     cell_ch_exp.size(), cell_names[0]);
            error_count += cell_ch_exp.size();
        end
    endtask

    initial begin
        error_count  = 0;
        checked      = 0;
        pending      = 0;
        report_ready = 1'b0;
        load_expected();
        pending = byte_exp.size() + cell_ch_exp.size();
        wait (arst_n === 1'b1);
        fork
            forever receive_peer_byte();
            forever capture_cell();
            begin
                wait (end_of_test === 1'b1);
                report_leftovers();
                report_ready = 1'b1;
            end
        join
    end

endmodule

//--- tb_terminal_link.sv
module tb_terminal_link;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT = 16;

    logic       clk;
    logic       arst_n;
    logic       key_valid;
    logic [7:0] key_code;
    logic       send_btn;
    logic [7:0] switches;
    logic       host_rx;
    logic       peer_rx;
    logic       cell_busy;
    logic       peer_tx;
    logic       cell_valid;
    logic [6:0] cell_x;
    logic [4:0] cell_y;
    logic [6:0] cell_char;
    logic       end_of_test;
    logic       report_ready;
    logic       records_loaded;
    int         pending;
    int         error_count;
    int         checked;
    int         local_errors;
    int         sends;
    int         seed;

    string      rec_name[$];
    string      rec_kind[$];
    logic [7:0] rec_data[$];
    int         rec_count[$];

    terminal_link_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .OUT_DEPTH    (8),
        .CELL_DEPTH   (4)
    ) i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .send_btn   (send_btn),
        .switches   (switches),
        .host_rx    (host_rx),
        .peer_rx    (peer_rx),
        .cell_busy  (cell_busy),
        .peer_tx    (peer_tx),
        .cell_valid (cell_valid),
        .cell_x     (cell_x),
        .cell_y     (cell_y),
        .cell_char  (cell_char)
    );

    tb_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .peer_tx      (peer_tx),
        .cell_valid   (cell_valid),
        .cell_busy    (cell_busy),
        .cell_x       (cell_x),
        .cell_y       (cell_y),
        .cell_char    (cell_char),
        .end_of_test  (end_of_test),
        .pending      (pending),
        .error_count  (error_count),
        .checked      (checked),
        .report_ready (report_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // Stimulus helpers
    // ====================
    task automatic read_records();
        int         fd;
        int         count;
        int         cx;
        int         cy;
        string      line;
        string      name;
        string      kind;
        logic [7:0] data;
        logic [7:0] exp_byte;
        fd = $fopen("link_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open link_input.txt");
            local_errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%s %s %h %d %d %d %h", name, kind, data, count, cx, cy,
                            exp_byte) == 7) begin
                    rec_name.push_back(name);
                    rec_kind.push_back(kind);
                    rec_data.push_back(data);
                    rec_count.push_back(count);
                    if (kind != "W") begin
                        sends += count;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_serial(input bit to_peer, input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            if (to_peer) begin
                peer_rx = frame[i];
            end else begin
                host_rx = frame[i];
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic strobe_sources(input bit key, input bit button, input logic [7:0] value);
        key_code  = value;
        switches  = key ? ~value : value;
        key_valid = key;
        send_btn  = button;
        @(negedge clk);
        key_valid = 1'b0;
        send_btn  = 1'b0;
        // Low for a full cycle so the next strobe is a fresh rising edge
        @(negedge clk);
    endtask

    // Runs alongside the following records
    task automatic hold_busy(input int cycles);
        fork
            begin
                cell_busy = 1'b1;
                repeat (cycles) @(negedge clk);
                cell_busy = 1'b0;
            end
        join_none
    endtask

    task automatic run_record(input int r);
        if (rec_kind[r] == "K") begin
            strobe_sources(1'b1, 1'b0, rec_data[r]);
        end else if (rec_kind[r] == "B") begin
            strobe_sources(1'b0, 1'b1, rec_data[r]);
        end else if (rec_kind[r] == "S") begin
            strobe_sources(1'b1, 1'b1, rec_data[r]);
        end else if (rec_kind[r] == "H" || rec_kind[r] == "P") begin
            for (int i = 0; i < rec_count[r]; i++) begin
                send_serial(rec_kind[r] == "P", rec_data[r]);
            end
        end else if (rec_kind[r] == "W") begin
            hold_busy(rec_count[r]);
        end else begin
            $display("Test %s has an unknown record kind %s", rec_name[r], rec_kind[r]);
            local_errors++;
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int gap;
        int waited;
        arst_n         = 1'b0;
        key_valid      = 1'b0;
        key_code       = 8'h00;
        send_btn       = 1'b0;
        switches       = 8'h00;
        host_rx        = 1'b1;
        peer_rx        = 1'b1;
        cell_busy      = 1'b0;
        end_of_test    = 1'b0;
        records_loaded = 1'b0;
        local_errors   = 0;
        sends          = 0;
        seed           = 32'ha4da;
        read_records();
        if (rec_kind.size() == 0) begin
            $display("No records were read from link_input.txt");
            local_errors++;
        end
        records_loaded = 1'b1;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);
        for (int r = 0; r < rec_kind.size(); r++) begin
            run_record(r);
            gap = $unsigned($random(seed)) % 16;
            repeat (gap) @(negedge clk);
        end
        // Let the outbound queue and cell queue drain
        waited = 0;
        while (pending != 0 && waited < 4000) begin
            @(negedge clk);
            waited++;
        end
        repeat (200) @(negedge clk);
        end_of_test = 1'b1;
        wait (report_ready === 1'b1);
        $display("Results checked %0d, errors %0d", checked, error_count + local_errors);
        if (error_count + local_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        wait (records_loaded === 1'b1);
        limit = sends * 400 + 2000;
        repeat (limit) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- terminal_link_top.sv
module terminal_link_top
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16,
    parameter int OUT_DEPTH    = 8,
    parameter int CELL_DEPTH   = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       key_valid,
    input  logic [7:0] key_code,
    input  logic       send_btn,
    input  logic [7:0] switches,
    input  logic       host_rx,
    input  logic       peer_rx,
    input  logic       cell_busy,
    output logic       peer_tx,
    output logic       cell_valid,
    output col_t       cell_x,
    output row_t       cell_y,
    output char_t      cell_char
);

    logic       host_valid;
    logic [7:0] host_data;
    logic       peer_valid;
    logic [7:0] peer_data;
    logic       out_push;
    char_t      out_char;
    logic       out_full;
    logic       out_empty;
    logic       out_pop;
    char_t      out_head;

    cell_if cells ();

    // ====================
    // Outbound path
    // ====================
    serial_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_host_rx (
        .clk        (clk),
        .arst_n     (arst_n),
        .line       (host_rx),
        .byte_valid (host_valid),
        .byte_data  (host_data)
    );

    source_arbiter i_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .send_btn   (send_btn),
        .switches   (switches),
        .host_valid (host_valid),
        .host_data  (host_data),
        .queue_full (out_full),
        .push       (out_push),
        .push_char  (out_char)
    );

    sync_fifo #(.WIDTH($bits(char_t)), .DEPTH(OUT_DEPTH)) i_out_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (out_push),
        .wr_data (out_char),
        .rd_en   (out_pop),
        .rd_data (out_head),
        .full    (out_full),
        .empty   (out_empty)
    );

    serial_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_peer_tx (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (out_empty),
        .head_char (out_head),
        .pop       (out_pop),
        .line      (peer_tx)
    );

    // ====================
    // Inbound path
    // ====================
    serial_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_peer_rx (
        .clk        (clk),
        .arst_n     (arst_n),
        .line       (peer_rx),
        .byte_valid (peer_valid),
        .byte_data  (peer_data)
    );

    cursor_tracker #(.CELL_DEPTH(CELL_DEPTH)) i_tracker (
        .clk        (clk),
        .arst_n     (arst_n),
        .byte_valid (peer_valid),
        .byte_data  (peer_data),
        .cells      (cells.tracker)
    );

    cell_queue #(.CELL_DEPTH(CELL_DEPTH)) i_cell_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .cell_busy  (cell_busy),
        .cells      (cells.queue),
        .cell_valid (cell_valid),
        .cell_x     (cell_x),
        .cell_y     (cell_y),
        .cell_char  (cell_char)
    );

endmodule
